/* qspi_consts.svh */
`ifndef QSPI_CONSTS_SVH
`define QSPI_CONSTS_SVH

// Flash address and data byte
`define QSPI_ADDR_WIDTH 32
`define QSPI_DATA_WIDTH 8

// One command byte on io0
`define QSPI_OPCODE_BITS 8

// Die selected by the C2h command
`define QSPI_DIE_NUMBER 8'h01

// Die select sends opcode then die number
`define QSPI_SWITCH_BITS (2 * `QSPI_OPCODE_BITS)

// Read opcode followed by the full address
`define QSPI_READ_BITS (`QSPI_OPCODE_BITS + `QSPI_ADDR_WIDTH)

// Turnaround before dual and quad data
`define QSPI_DUMMY_CYCLES 8

// Sequencer counter, wide enough for the read command
`define QSPI_COUNT_WIDTH 6

`endif

/* qspi_pkg.sv */
`default_nettype none

package qspi_pkg;

    // Transaction phases of the read sequencer
    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_SWITCH_DIE = 3'd1,
        ST_GAP        = 3'd2,   // cs_n high between die select and read
        ST_COMMAND    = 3'd3,
        ST_DUMMY      = 3'd4,
        ST_DATA       = 3'd5,
        ST_WRITE      = 3'd6,
        ST_DONE       = 3'd7
    } qspi_state_t;

    typedef enum logic [1:0] {
        MODE_SINGLE   = 2'b00,
        MODE_DUAL     = 2'b01,
        MODE_QUAD     = 2'b10,
        MODE_RESERVED = 2'b11   // Read as single
    } qspi_mode_t;

    typedef enum logic [7:0] {
        OP_SWITCH_DIE = 8'hC2,
        OP_READ       = 8'h13,
        OP_DUAL_READ  = 8'h3C,
        OP_QUAD_READ  = 8'h6C
    } qspi_opcode_t;

endpackage

`default_nettype wire

/* qspi_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "qspi_consts.svh"

module qspi_sequencer
    import qspi_pkg::*;
(
    input  logic       system_clk,
    input  logic       system_reset_n,
    input  logic       read_flag,
    input  logic       switch_die,
    input  logic [1:0] mode,
    output logic       cs_n,
    output logic       ready,
    output logic       read_done,
    output logic       load_switch,
    output logic       load_read,
    output logic       shift_en,
    output logic       cmd_out_en,
    output logic       sample_en,
    output logic       byte_valid,
    output qspi_mode_t read_mode
);

    localparam int CW = `QSPI_COUNT_WIDTH;

    localparam logic [CW-1:0] SWITCH_LAST = CW'(`QSPI_SWITCH_BITS - 1);
    localparam logic [CW-1:0] READ_LAST   = CW'(`QSPI_READ_BITS - 1);
    localparam logic [CW-1:0] READ_TURN   = CW'(`QSPI_READ_BITS - 2);
    localparam logic [CW-1:0] DUMMY_LAST  = CW'(`QSPI_DUMMY_CYCLES - 1);
    localparam logic [CW-1:0] DUMMY_TURN  = CW'(`QSPI_DUMMY_CYCLES - 2);

    qspi_state_t   state;
    logic [CW-1:0] count;
    logic [CW-1:0] data_last;
    logic          single_read;
    logic          cmd_phase;

    assign single_read = (read_mode != MODE_DUAL) && (read_mode != MODE_QUAD);

    // Count of the last data beat, less the one taken in the previous phase
    always_comb
    begin
        case (read_mode)
            MODE_DUAL: data_last = CW'(`QSPI_DATA_WIDTH / 2 - 2);
            MODE_QUAD: data_last = CW'(`QSPI_DATA_WIDTH / 4 - 2);
            default:   data_last = CW'(`QSPI_DATA_WIDTH - 2);
        endcase
    end

    assign cmd_phase  = (state == ST_SWITCH_DIE) || (state == ST_COMMAND);
    assign shift_en   = cmd_phase;
    assign cmd_out_en = cmd_phase;   // io0 released in dummy and data

    always_ff @(negedge system_clk)
    begin
        if (!system_reset_n)
        begin
            state       <= ST_IDLE;
            count       <= '0;
            read_mode   <= MODE_SINGLE;
            cs_n        <= 1'b1;
            ready       <= 1'b1;
            read_done   <= 1'b0;
            load_switch <= 1'b0;
            load_read   <= 1'b0;
            sample_en   <= 1'b0;
            byte_valid  <= 1'b0;
        end
        else
        begin
            load_switch <= 1'b0;
            load_read   <= 1'b0;
            byte_valid  <= 1'b0;
            read_done   <= 1'b0;
            count       <= count + 1'b1;

            case (state)
                ST_IDLE:
                begin
                    ready <= 1'b1;
                    if (load_switch || load_read)
                    begin
                        // Shifter is loaded on this edge
                        state <= load_switch ? ST_SWITCH_DIE : ST_COMMAND;
                        count <= '0;
                        cs_n  <= 1'b0;
                        ready <= 1'b0;
                    end
                    else if (ready && read_flag)
                    begin
                        read_mode   <= qspi_mode_t'(mode);
                        load_switch <= switch_die;
                        load_read   <= !switch_die;
                    end
                end
                ST_SWITCH_DIE:
                begin
                    if (count == SWITCH_LAST)
                    begin
                        state     <= ST_GAP;
                        cs_n      <= 1'b1;
                        load_read <= 1'b1;
                    end
                end
                ST_GAP:
                begin
                    state <= ST_COMMAND;
                    count <= '0;
                    cs_n  <= 1'b0;
                end
                ST_COMMAND:
                begin
                    if (single_read && count == READ_TURN)
                        sample_en <= 1'b1;   // First bit arrives during the last address bit
                    if (count == READ_LAST)
                    begin
                        state <= single_read ? ST_DATA : ST_DUMMY;
                        count <= '0;
                    end
                end
                ST_DUMMY:
                begin
                    if (count == DUMMY_TURN)
                        sample_en <= 1'b1;
                    if (count == DUMMY_LAST)
                    begin
                        state <= ST_DATA;
                        count <= '0;
                    end
                end
                ST_DATA:
                begin
                    if (count == data_last)
                    begin
                        state      <= ST_WRITE;
                        sample_en  <= 1'b0;
                        byte_valid <= 1'b1;
                    end
                end
                ST_WRITE:
                begin
                    state <= ST_DONE;
                    cs_n  <= 1'b1;   // Together with write_req
                end
                ST_DONE:
                begin
                    state     <= ST_IDLE;
                    read_done <= 1'b1;
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* qspi_command_shifter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "qspi_consts.svh"

module qspi_command_shifter
    import qspi_pkg::*;
(
    input  logic                        system_clk,
    input  logic                        system_reset_n,
    input  logic [`QSPI_ADDR_WIDTH-1:0] read_addr,
    input  qspi_mode_t                  read_mode,
    input  logic                        load_switch,
    input  logic                        load_read,
    input  logic                        shift_en,
    output logic                        cmd_bit
);

    localparam int SR_BITS  = `QSPI_READ_BITS;
    localparam int PAD_BITS = `QSPI_READ_BITS - `QSPI_SWITCH_BITS;

    logic [SR_BITS-1:0] shift_reg;
    qspi_opcode_t       read_opcode;

    always_comb
    begin
        case (read_mode)
            MODE_DUAL: read_opcode = OP_DUAL_READ;
            MODE_QUAD: read_opcode = OP_QUAD_READ;
            default:   read_opcode = OP_READ;   // Reserved mode too
        endcase
    end

    // Command is left aligned so the MSB leaves first
    always_ff @(negedge system_clk)
    begin
        if (!system_reset_n)
        begin
            shift_reg <= '0;
        end
        else if (load_switch)
        begin
            shift_reg <= {OP_SWITCH_DIE, `QSPI_DIE_NUMBER, {PAD_BITS{1'b0}}};
        end
        else if (load_read)
        begin
            shift_reg <= {read_opcode, read_addr};   // Address held from here on
        end
        else if (shift_en)
        begin
            shift_reg <= {shift_reg[SR_BITS-2:0], 1'b0};
        end
    end

    assign cmd_bit = shift_reg[SR_BITS-1];

endmodule

`default_nettype wire

/* qspi_data_capture.sv */
`timescale 1ns/1ns
`default_nettype none

`include "qspi_consts.svh"

module qspi_data_capture
    import qspi_pkg::*;
(
    input  logic                        system_clk,
    input  logic                        system_reset_n,
    input  qspi_mode_t                  read_mode,
    input  logic                        sample_en,
    input  logic                        byte_valid,
    input  logic [3:0]                  io_in,
    output logic [`QSPI_DATA_WIDTH-1:0] data_qspi2fifo,
    output logic                        write_req
);

    localparam int DW = `QSPI_DATA_WIDTH;

    logic [DW-1:0] shift_reg;
    logic [DW-1:0] shift_next;

    // MSB first on every lane width
    always_comb
    begin
        case (read_mode)
            MODE_DUAL:
            begin
                shift_next = {shift_reg[DW-3:0], io_in[1], io_in[0]};
            end
            MODE_QUAD:
            begin
                shift_next = {shift_reg[DW-5:0], io_in[3:0]};
            end
            default:
            begin
                shift_next = {shift_reg[DW-2:0], io_in[1]};   // Single data on io1
            end
        endcase
    end

    always_ff @(negedge system_clk)
    begin
        if (sample_en)
        begin
            shift_reg <= shift_next;
        end
        if (byte_valid)
        begin
            data_qspi2fifo <= shift_reg;
        end
    end

    // One strobe per byte without back-pressure
    always_ff @(negedge system_clk)
    begin
        if (!system_reset_n)
        begin
            write_req <= 1'b0;
        end
        else
        begin
            write_req <= byte_valid;
        end
    end

endmodule

`default_nettype wire

/* qspi_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module qspi_controller
    import qspi_pkg::*;
(
    input  logic        system_clk,
    input  logic        system_reset_n,
    input  logic        read_flag,
    input  logic [31:0] read_addr,
    input  logic        switch_die,
    input  logic [1:0]  mode,
    output logic        spi_clk,
    output logic        cs_n,
    inout  wire         io0,
    inout  wire         io1,
    inout  wire         io2,
    inout  wire         io3,
    output logic [7:0]  data_qspi2fifo,
    output logic        write_req,
    output logic        ready,
    output logic        read_done
);

    logic       load_switch;
    logic       load_read;
    logic       shift_en;
    logic       cmd_out_en;
    logic       sample_en;
    logic       byte_valid;
    logic       cmd_bit;
    qspi_mode_t read_mode;

    // Flash clock held low in reset
    assign spi_clk = system_reset_n ? system_clk : 1'b0;

    assign io0 = cmd_out_en ? cmd_bit : 1'bz;
    assign io1 = 1'bz;   // Input only
    assign io2 = 1'bz;
    assign io3 = 1'bz;

    qspi_sequencer u_sequencer (
        .system_clk     (system_clk),
        .system_reset_n (system_reset_n),
        .read_flag      (read_flag),
        .switch_die     (switch_die),
        .mode           (mode),
        .cs_n           (cs_n),
        .ready          (ready),
        .read_done      (read_done),
        .load_switch    (load_switch),
        .load_read      (load_read),
        .shift_en       (shift_en),
        .cmd_out_en     (cmd_out_en),
        .sample_en      (sample_en),
        .byte_valid     (byte_valid),
        .read_mode      (read_mode)
    );

    qspi_command_shifter u_command_shifter (
        .system_clk     (system_clk),
        .system_reset_n (system_reset_n),
        .read_addr      (read_addr),
        .read_mode      (read_mode),
        .load_switch    (load_switch),
        .load_read      (load_read),
        .shift_en       (shift_en),
        .cmd_bit        (cmd_bit)
    );

    qspi_data_capture u_data_capture (
        .system_clk     (system_clk),
        .system_reset_n (system_reset_n),
        .read_mode      (read_mode),
        .sample_en      (sample_en),
        .byte_valid     (byte_valid),
        .io_in          ({io3, io2, io1, io0}),
        .data_qspi2fifo (data_qspi2fifo),
        .write_req      (write_req)
    );

endmodule

`default_nettype wire

/* qspi_flash_model.sv */
`timescale 1ns/1ns
`default_nettype none

module qspi_flash_model
    import qspi_pkg::*;
(
    input  logic       spi_clk,
    input  logic       cs_n,
    inout  wire        io0,
    inout  wire        io1,
    inout  wire        io2,
    inout  wire        io3,
    output logic       bad_command,
    output logic       die_one,
    output logic [7:0] last_opcode
);

    int         edge_count;
    logic [7:0] opcode;
    logic [7:0] die_bits;
    logic [31:0] addr;
    logic [7:0] rd_byte;
    logic [3:0] drive_en;
    logic [3:0] drive_val;
    int         beat;

    assign io0 = drive_en[0] ? drive_val[0] : 1'bz;
    assign io1 = drive_en[1] ? drive_val[1] : 1'bz;
    assign io2 = drive_en[2] ? drive_val[2] : 1'bz;
    assign io3 = drive_en[3] ? drive_val[3] : 1'bz;

    initial
    begin
        bad_command = 1'b0;
        die_one     = 1'b0;
        last_opcode = 8'h00;
        edge_count  = 0;
        drive_en    = 4'b0000;
        drive_val   = 4'b0000;
    end

    // Command bits are taken before any data is driven on the same edge
    always @(posedge spi_clk or posedge cs_n)
    begin
        if (cs_n)
        begin
            edge_count = 0;
            drive_en   = 4'b0000;
        end
        else
        begin
            if (edge_count < 8)
                opcode = {opcode[6:0], io0};
            else if (opcode == OP_SWITCH_DIE && edge_count < 16)
                die_bits = {die_bits[6:0], io0};
            else if (edge_count < 40)
                addr = {addr[30:0], io0};

            if (edge_count == 7)
            begin
                last_opcode = opcode;
                if (opcode != OP_SWITCH_DIE && opcode != OP_READ &&
                    opcode != OP_DUAL_READ && opcode != OP_QUAD_READ)
                    bad_command = 1'b1;
            end
            if (opcode == OP_SWITCH_DIE && edge_count == 15)
            begin
                if (die_bits == 8'h01)
                    die_one = 1'b1;
                else
                    bad_command = 1'b1;
            end
            if (edge_count == 39)
                rd_byte = addr[7:0] ^ addr[15:8] ^ 8'h5A ^ {8{die_one}};

            drive_en = 4'b0000;
            if (opcode == OP_READ)
            begin
                beat = edge_count - 39;   // Data starts right after the last address bit
                if (beat >= 0 && beat < 8)
                begin
                    drive_en     = 4'b0010;
                    drive_val[1] = rd_byte[7 - beat];
                end
            end
            else if (opcode == OP_DUAL_READ)
            begin
                beat = edge_count - 47;
                if (beat >= 0 && beat < 4)
                begin
                    drive_en       = 4'b0011;
                    drive_val[1:0] = rd_byte[7 - 2 * beat -: 2];
                end
            end
            else if (opcode == OP_QUAD_READ)
            begin
                beat = edge_count - 47;
                if (beat >= 0 && beat < 2)
                begin
                    drive_en  = 4'b1111;
                    drive_val = rd_byte[7 - 4 * beat -: 4];
                end
            end
            edge_count = edge_count + 1;
        end
    end

endmodule

`default_nettype wire

/* qspi_controller_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module qspi_controller_assertions (
    input logic system_clk,
    input logic system_reset_n,
    input logic cs_n,
    input logic ready,
    input logic write_req,
    input logic read_done,
    input logic cmd_out_en
);

    // Outputs move on the falling edge, so the rising edge sees them settled
    a_write_req_single: assert property (@(posedge system_clk) disable iff (!system_reset_n)
        write_req |=> !write_req)
        else $error("write_req stayed high for more than one cycle");

    a_done_after_write: assert property (@(posedge system_clk) disable iff (!system_reset_n)
        write_req |=> read_done)
        else $error("read_done did not follow write_req");

    a_done_needs_write: assert property (@(posedge system_clk) disable iff (!system_reset_n)
        read_done |-> $past(write_req))
        else $error("read_done without a preceding write_req");

    a_idle_outputs: assert property (@(posedge system_clk) disable iff (!system_reset_n)
        ready |-> (cs_n && !write_req && !read_done))
        else $error("bus not idle while ready is high");

    // io0 released outside the command phases
    a_io0_in_command: assert property (@(posedge system_clk) disable iff (!system_reset_n)
        cmd_out_en |-> !cs_n)
        else $error("io0 driven while chip select is high");

    // Dummy and data cycles leave io0 to the flash until chip select rises
    a_io0_stays_released: assert property (@(posedge system_clk) disable iff (!system_reset_n)
        (!cs_n && !cmd_out_en) |=> (cs_n || !cmd_out_en))
        else $error("io0 driven again during dummy or data cycles");

    a_cs_with_write: assert property (@(posedge system_clk) disable iff (!system_reset_n)
        write_req |-> cs_n)
        else $error("chip select still low when the byte was written");

endmodule

`default_nettype wire

/* qspi_controller_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "qspi_consts.svh"

module qspi_controller_tb
    import qspi_pkg::*;
;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 10;
    localparam int TOTAL_READS     = 20;
    localparam int CYCLES_PER_READ = 100;
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + TOTAL_READS * CYCLES_PER_READ;

    logic        system_clk;
    logic        system_reset_n;
    logic        read_flag;
    logic [31:0] read_addr;
    logic        switch_die;
    logic [1:0]  mode;
    logic        spi_clk;
    logic        cs_n;
    wire         io0;
    wire         io1;
    wire         io2;
    wire         io3;
    logic [7:0]  data_qspi2fifo;
    logic        write_req;
    logic        ready;
    logic        read_done;
    logic        bad_command;
    logic        die_one;
    logic [7:0]  last_opcode;

    int          tests_run;
    int          tests_failed;
    int          write_count;
    logic [31:0] lcg_state;
    logic        die_expected;

    qspi_controller UUT (
        .system_clk     (system_clk),
        .system_reset_n (system_reset_n),
        .read_flag      (read_flag),
        .read_addr      (read_addr),
        .switch_die     (switch_die),
        .mode           (mode),
        .spi_clk        (spi_clk),
        .cs_n           (cs_n),
        .io0            (io0),
        .io1            (io1),
        .io2            (io2),
        .io3            (io3),
        .data_qspi2fifo (data_qspi2fifo),
        .write_req      (write_req),
        .ready          (ready),
        .read_done      (read_done)
    );

    qspi_flash_model flash (
        .spi_clk     (spi_clk),
        .cs_n        (cs_n),
        .io0         (io0),
        .io1         (io1),
        .io2         (io2),
        .io3         (io3),
        .bad_command (bad_command),
        .die_one     (die_one),
        .last_opcode (last_opcode)
    );

    bind qspi_controller qspi_controller_assertions u_assertions (
        .system_clk     (system_clk),
        .system_reset_n (system_reset_n),
        .cs_n           (cs_n),
        .ready          (ready),
        .write_req      (write_req),
        .read_done      (read_done),
        .cmd_out_en     (cmd_out_en)
    );

    initial
    begin
        system_clk = 1'b0;
        forever #(CLK_PERIOD / 2) system_clk = ~system_clk;
    end

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge system_clk);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    always @(posedge system_clk)
    begin
        if (system_reset_n && write_req)
            write_count <= write_count + 1;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Byte the flash holds at an address
    function automatic logic [7:0] flash_byte(input logic [31:0] addr, input logic die);
        return addr[7:0] ^ addr[15:8] ^ 8'h5A ^ (die ? 8'hFF : 8'h00);
    endfunction

    function automatic logic [7:0] opcode_for(input logic [1:0] rd_mode);
        case (rd_mode)
            2'b01:   return 8'h3C;
            2'b10:   return 8'h6C;
            default: return 8'h13;
        endcase
    endfunction

    task automatic run_read(input string name, input logic [31:0] addr,
                            input logic [1:0] rd_mode, input logic sw, input logic poke_busy);
        int         wait_cycles;
        int         start_count;
        logic [7:0] expected;
        logic       ok;
        ok = 1'b1;
        while (!ready)
            @(posedge system_clk);
        start_count = write_count;
        @(posedge system_clk);
        #2;
        read_flag  = 1'b1;
        read_addr  = addr;
        mode       = rd_mode;
        switch_die = sw;
        @(posedge system_clk);
        #2;
        read_flag = 1'b0;
        if (poke_busy)
        begin
            repeat (5) @(posedge system_clk);
            #2;
            read_flag = 1'b1;   // Must be ignored while busy
            read_addr = ~addr;
            @(posedge system_clk);
            #2;
            read_flag = 1'b0;
        end
        if (sw)
            die_expected = 1'b1;
        expected = flash_byte(addr, die_expected);
        wait_cycles = 0;
        do
        begin
            @(posedge system_clk);
            wait_cycles++;
        end
        while (!write_req && wait_cycles < CYCLES_PER_READ);
        if (!write_req)
        begin
            $display("Test %s: no write_req within %0d cycles", name, CYCLES_PER_READ);
            ok = 1'b0;
        end
        else if (data_qspi2fifo !== expected)
        begin
            $display("MISMATCH %s: expected %02h, actual %02h", name, expected, data_qspi2fifo);
            ok = 1'b0;
        end
        while (!ready)
            @(posedge system_clk);
        if (write_count != start_count + 1)
        begin
            $display("Test %s: %0d bytes written for one request", name,
                     write_count - start_count);
            ok = 1'b0;
        end
        if (last_opcode !== opcode_for(rd_mode))
        begin
            $display("MISMATCH %s opcode: expected %02h, actual %02h", name,
                     opcode_for(rd_mode), last_opcode);
            ok = 1'b0;
        end
        if (bad_command || die_one !== die_expected)
        begin
            $display("Test %s: flash saw a bad command or the wrong die", name);
            ok = 1'b0;
        end
        tests_run++;
        if (!ok)
            tests_failed++;
        $display("Test %s: %s", name, ok ? "ok" : "failed");
    endtask

    initial
    begin
        system_reset_n = 1'b0;
        read_flag      = 1'b0;
        read_addr      = 32'h0;
        switch_die     = 1'b0;
        mode           = 2'b00;
        tests_run      = 0;
        tests_failed   = 0;
        write_count    = 0;
        lcg_state      = 32'hf76c_c806;
        die_expected   = 1'b0;
        repeat (RESET_CYCLES) @(posedge system_clk);
        #2;
        system_reset_n = 1'b1;

        for (int i = 0; i < 5; i++)
            run_read($sformatf("single_%0d", i), next_random(), 2'b00, 1'b0, i == 0);
        for (int i = 0; i < 5; i++)
            run_read($sformatf("dual_%0d", i), next_random(), 2'b01, 1'b0, i == 1);
        for (int i = 0; i < 5; i++)
            run_read($sformatf("quad_%0d", i), next_random(), 2'b10, 1'b0, 1'b0);
        run_read("switch_die", next_random(), 2'b00, 1'b1, 1'b0);
        for (int i = 0; i < 2; i++)
            run_read($sformatf("reserved_mode_%0d", i), next_random(), 2'b11, 1'b0, 1'b0);

        $display("Tests run %0d, passed %0d, failed %0d", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (tests_failed == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
qspi_pkg.sv
qspi_sequencer.sv
qspi_command_shifter.sv
qspi_data_capture.sv
qspi_controller.sv
qspi_flash_model.sv
qspi_controller_assertions.sv
qspi_controller_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module qspi_controller_tb -o qspi_sim

output=$(./obj_dir/qspi_sim)
echo "$output"

if grep -qx ">>> PASS" <<< "$output"; then
    exit 0
else
    exit 1
fi
